// ==== common/crypto_pkg.sv ====
// Shared types for the scalar crypto unit
package crypto_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int XLEN = 64; // RV64 only

    // ------------------------------
    // Opcodes
    // ------------------------------
    typedef enum logic [3:0] {
        op_none        = 4'd0,  // Idle or unsupported
        op_sha256_sig0 = 4'd1,
        op_sha256_sig1 = 4'd2,
        op_sha256_sum0 = 4'd3,
        op_sha256_sum1 = 4'd4,
        op_sha512_sig0 = 4'd5,
        op_sha512_sig1 = 4'd6,
        op_sha512_sum0 = 4'd7,
        op_sha512_sum1 = 4'd8,
        op_sm3_p0      = 4'd9,  // SM3 permutation P0
        op_sm3_p1      = 4'd10  // SM3 permutation P1
    } crypto_op_e;

    // ------------------------------
    // Request and writeback words
    // ------------------------------

    // Issue side request, 78 bits
    typedef struct packed {
        logic             valid;   // Request present
        crypto_op_e       op;      // Instruction to run
        logic [XLEN-1:0]  rs1;     // Source register 1
        logic [4:0]       rd_addr; // Destination register index
        logic [3:0]       imm;     // Encoding immediate, unused by kept ops
    } crypto_req_t;

    // Writeback word, 70 bits
    typedef struct packed {
        logic             valid;   // One cycle pulse per result
        logic [4:0]       rd_addr; // Destination register index
        logic [XLEN-1:0]  data;    // Result value
    } crypto_wb_t;

endpackage

// ==== crypto_fu/riscv_crypto_fu_ssha256.sv ====
`timescale 1ns/1ps

// SHA-256 sigma and sum functions on the low word of rs1
module riscv_crypto_fu_ssha256 (
    input  logic                          valid, // Group selected
    input  crypto_pkg::crypto_op_e        op,    // Which function
    input  logic [31:0]                   rs1,   // Low word of source
    output logic                          ready, // Result available
    output logic [crypto_pkg::XLEN-1:0]   rd     // Sign-extended result
);
    import crypto_pkg::*;

    logic [31:0] res32; // Raw 32-bit result

    // Rotate right by a constant amount
    function automatic logic [31:0] ror32(input logic [31:0] x, input int unsigned sh);
        ror32 = (x >> sh) | (x << (32 - sh));
    endfunction

    // ------------------------------
    // Function select
    // ------------------------------
    always_comb begin
        case (op)
            op_sha256_sig0: begin
                res32 = ror32(rs1, 7) ^ ror32(rs1, 18) ^ (rs1 >> 3);   // Message schedule
            end
            op_sha256_sig1: begin
                res32 = ror32(rs1, 17) ^ ror32(rs1, 19) ^ (rs1 >> 10); // Message schedule
            end
            op_sha256_sum0: begin
                res32 = ror32(rs1, 2) ^ ror32(rs1, 13) ^ ror32(rs1, 22); // Round on a
            end
            op_sha256_sum1: begin
                res32 = ror32(rs1, 6) ^ ror32(rs1, 11) ^ ror32(rs1, 25); // Round on e
            end
            default: begin
                res32 = '0; // Not a SHA-256 op
            end
        endcase
    end

    // Single cycle, done as soon as selected
    assign ready = valid;

    // Sign extend to XLEN
    assign rd = {{(XLEN-32){res32[31]}}, res32};

endmodule

// ==== crypto_fu/riscv_crypto_fu_ssha512.sv ====
`timescale 1ns/1ps

// SHA-512 sigma and sum functions on the full rs1 word
module riscv_crypto_fu_ssha512 (
    input  logic                          valid, // Group selected
    input  crypto_pkg::crypto_op_e        op,    // Which function
    input  logic [crypto_pkg::XLEN-1:0]   rs1,   // Full source word
    output logic                          ready, // Result available
    output logic [crypto_pkg::XLEN-1:0]   rd     // 64-bit result
);
    import crypto_pkg::*;

    logic [XLEN-1:0] res64; // Selected result

    // Rotate right by a constant amount
    function automatic logic [63:0] ror64(input logic [63:0] x, input int unsigned sh);
        ror64 = (x >> sh) | (x << (64 - sh));
    endfunction

    // ------------------------------
    // Function select
    // ------------------------------
    always_comb begin
        case (op)
            op_sha512_sig0: begin
                res64 = ror64(rs1, 1) ^ ror64(rs1, 8) ^ (rs1 >> 7);    // Message schedule
            end
            op_sha512_sig1: begin
                res64 = ror64(rs1, 19) ^ ror64(rs1, 61) ^ (rs1 >> 6);  // Message schedule
            end
            op_sha512_sum0: begin
                res64 = ror64(rs1, 28) ^ ror64(rs1, 34) ^ ror64(rs1, 39); // Round on a
            end
            op_sha512_sum1: begin
                res64 = ror64(rs1, 14) ^ ror64(rs1, 18) ^ ror64(rs1, 41); // Round on e
            end
            default: begin
                res64 = '0; // Not a SHA-512 op
            end
        endcase
    end

    // Single cycle, no handshake delay
    assign ready = valid;

    // Full width already, no extension
    assign rd = res64;

endmodule

// ==== crypto_fu/riscv_crypto_fu_ssm3.sv ====
`timescale 1ns/1ps

// SM3 permutations P0 and P1 on the low word of rs1
module riscv_crypto_fu_ssm3 (
    input  logic                          valid, // Group selected
    input  crypto_pkg::crypto_op_e        op,    // P0 or P1
    input  logic [31:0]                   rs1,   // Low word of source
    output logic                          ready, // Result available
    output logic [crypto_pkg::XLEN-1:0]   rd     // Sign-extended result
);
    import crypto_pkg::*;

    logic [31:0] res32; // Raw permutation output

    // Rotate left by a constant amount
    function automatic logic [31:0] rol32(input logic [31:0] x, input int unsigned sh);
        rol32 = (x << sh) | (x >> (32 - sh));
    endfunction

    always_comb begin
        case (op)
            op_sm3_p0: begin
                res32 = rs1 ^ rol32(rs1, 9) ^ rol32(rs1, 17);  // Compression function
            end
            op_sm3_p1: begin
                res32 = rs1 ^ rol32(rs1, 15) ^ rol32(rs1, 23); // Message expansion
            end
            default: begin
                res32 = '0;
            end
        endcase
    end

    assign ready = valid; // Purely combinational

    // Upper half follows bit 31
    assign rd = {{(XLEN-32){res32[31]}}, res32};

endmodule

// ==== crypto_fu/riscv_crypto_fu.sv ====
`timescale 1ns/1ps

// Scalar crypto functional unit
// Combinational, ready in the same cycle as valid for an enabled group
module riscv_crypto_fu #(
    parameter bit SSHA256_EN   = 1'b1, // SHA-256 group present
    parameter bit SSHA512_EN   = 1'b1, // SHA-512 group present
    parameter bit SSM3_EN      = 1'b1, // SM3 group present
    parameter bit LOGIC_GATING = 1'b0  // Mask operands of idle groups
) (
    input  logic                          g_clk,  // Global clock
    input  logic                          arst_n, // Async reset, active low
    input  crypto_pkg::crypto_req_t       req,    // Request word
    output logic                          ready,  // Result valid this cycle
    output logic [crypto_pkg::XLEN-1:0]   result  // Merged result
);
    import crypto_pkg::*;

    // Per group valid, operand, ready and result
    logic            sha256_valid;
    logic [31:0]     sha256_rs1;
    logic            sha256_ready;
    logic [XLEN-1:0] sha256_result;

    logic            sha512_valid;
    logic [XLEN-1:0] sha512_rs1;
    logic            sha512_ready;
    logic [XLEN-1:0] sha512_result;

    logic            sm3_valid;
    logic [31:0]     sm3_rs1;
    logic            sm3_ready;
    logic [XLEN-1:0] sm3_result;

    // ------------------------------
    // Operand gating
    // ------------------------------
    // Idle blocks see zero operands when gating is on
    assign sha256_rs1 = LOGIC_GATING ? ({32{sha256_valid}} & req.rs1[31:0])
                                     : req.rs1[31:0];
    assign sha512_rs1 = LOGIC_GATING ? ({XLEN{sha512_valid}} & req.rs1)
                                     : req.rs1;
    assign sm3_rs1    = LOGIC_GATING ? ({32{sm3_valid}} & req.rs1[31:0])
                                     : req.rs1[31:0];

    // ------------------------------
    // SHA-256 group
    // ------------------------------
    if (SSHA256_EN) begin : g_ssha256
        assign sha256_valid = req.valid && (req.op inside {op_sha256_sig0, op_sha256_sig1,
                                                           op_sha256_sum0, op_sha256_sum1});
        riscv_crypto_fu_ssha256 i_ssha256 (
            .valid (sha256_valid),
            .op    (req.op),
            .rs1   (sha256_rs1),
            .ready (sha256_ready),
            .rd    (sha256_result)
        );
    end else begin : g_no_ssha256
        assign sha256_valid  = 1'b0; // Opcode never accepted
        assign sha256_ready  = 1'b0;
        assign sha256_result = '0;
    end

    // ------------------------------
    // SHA-512 group
    // ------------------------------
    if (SSHA512_EN) begin : g_ssha512
        assign sha512_valid = req.valid && (req.op inside {op_sha512_sig0, op_sha512_sig1,
                                                           op_sha512_sum0, op_sha512_sum1});
        riscv_crypto_fu_ssha512 i_ssha512 (
            .valid (sha512_valid),
            .op    (req.op),
            .rs1   (sha512_rs1),
            .ready (sha512_ready),
            .rd    (sha512_result)
        );
    end else begin : g_no_ssha512
        assign sha512_valid  = 1'b0;
        assign sha512_ready  = 1'b0;
        assign sha512_result = '0;
    end

    // ------------------------------
    // SM3 group
    // ------------------------------
    if (SSM3_EN) begin : g_ssm3
        assign sm3_valid = req.valid && (req.op inside {op_sm3_p0, op_sm3_p1});
        riscv_crypto_fu_ssm3 i_ssm3 (
            .valid (sm3_valid),
            .op    (req.op),
            .rs1   (sm3_rs1),
            .ready (sm3_ready),
            .rd    (sm3_result)
        );
    end else begin : g_no_ssm3
        assign sm3_valid  = 1'b0;
        assign sm3_ready  = 1'b0;
        assign sm3_result = '0;
    end

    // ------------------------------
    // Result merge
    // ------------------------------
    // Disabled or unknown opcodes leave ready low and stall the requester
    assign ready = sha256_ready | sha512_ready | sm3_ready;

    // At most one group valid at a time
    assign result = ({XLEN{sha256_valid}} & sha256_result) |
                    ({XLEN{sha512_valid}} & sha512_result) |
                    ({XLEN{sm3_valid}}    & sm3_result);

endmodule

// ==== logic/crypto_wb.sv ====
`timescale 1ns/1ps

// Writeback stage
// One register between the functional unit and the register file port
module crypto_wb (
    input  logic                          g_clk,   // Global clock
    input  logic                          arst_n,  // Async reset, active low
    input  logic                          fire,    // Request accepted this cycle
    input  logic [4:0]                    rd_addr, // Destination register
    input  logic [crypto_pkg::XLEN-1:0]   data,    // Combinational result
    output crypto_pkg::crypto_wb_t        wb       // Registered writeback word
);
    import crypto_pkg::*;

    crypto_wb_t wb_q; // Stage register

    // ------------------------------
    // Valid pulse
    // ------------------------------
    // High for exactly the cycle after each fire
    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_q.valid <= 1'b0;
        end else begin
            wb_q.valid <= fire;
        end
    end

    // ------------------------------
    // Payload
    // ------------------------------
    // Captured on fire, held until the next one
    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_q.rd_addr <= '0;
            wb_q.data    <= '0; // Known zero out of reset
        end else if (fire) begin
            wb_q.rd_addr <= rd_addr;
            wb_q.data    <= data;
        end
    end

    assign wb = wb_q;

endmodule

// ==== logic/crypto_unit_top.sv ====
`timescale 1ns/1ps

// Crypto unit top level
// Functional unit followed by a one cycle writeback stage
module crypto_unit_top #(
    parameter bit SSHA256_EN   = 1'b1, // SHA-256 group present
    parameter bit SSHA512_EN   = 1'b1, // SHA-512 group present
    parameter bit SSM3_EN      = 1'b1, // SM3 group present
    parameter bit LOGIC_GATING = 1'b0  // Operand gating in the unit
) (
    input  logic                      g_clk,  // Global clock
    input  logic                      arst_n, // Async reset, active low
    input  crypto_pkg::crypto_req_t   req,    // Request from issue
    output logic                      ready,  // Request accepted
    output crypto_pkg::crypto_wb_t    wb      // Writeback to register file
);
    import crypto_pkg::*;

    logic [XLEN-1:0] fu_result; // Combinational unit output
    logic            fire;      // Handshake complete

    assign fire = req.valid & ready;

    // ------------------------------
    // Functional unit
    // ------------------------------
    riscv_crypto_fu #(
        .SSHA256_EN   (SSHA256_EN),
        .SSHA512_EN   (SSHA512_EN),
        .SSM3_EN      (SSM3_EN),
        .LOGIC_GATING (LOGIC_GATING)
    ) i_crypto_fu (
        .g_clk  (g_clk),
        .arst_n (arst_n),
        .req    (req),
        .ready  (ready),
        .result (fu_result)
    );

    // ------------------------------
    // Writeback stage
    // ------------------------------
    crypto_wb i_crypto_wb (
        .g_clk   (g_clk),
        .arst_n  (arst_n),
        .fire    (fire),
        .rd_addr (req.rd_addr), // Tag travels with the result
        .data    (fu_result),
        .wb      (wb)
    );

endmodule

// ==== tb/crypto_unit_asserts.sv ====
`timescale 1ns/1ps

module crypto_unit_asserts #(
    parameter bit WB_SIDE = 1'b0 // Writeback checks instead of handshake checks
) (
    input logic g_clk,
    input logic arst_n,
    input logic req_valid, // Request valid seen at this site
    input logic ready,     // Unit ready
    input logic fire,      // Accepted request
    input logic wb_valid   // Writeback pulse
);

    int fail_count = 0; // Failed assertions at this site

    if (!WB_SIDE) begin : g_handshake
        // ------------------------------
        // Handshake
        // ------------------------------
        ready_needs_valid: assert property (@(posedge g_clk) disable iff (!arst_n)
            ready |-> req_valid)
            else begin
                $error("ready high without req.valid");
                fail_count++;
            end
    end else begin : g_writeback
        // ------------------------------
        // Writeback timing
        // ------------------------------
        wb_follows_fire: assert property (@(posedge g_clk) disable iff (!arst_n)
            fire |=> wb_valid)
            else begin
                $error("No writeback one cycle after an accepted request");
                fail_count++;
            end

        wb_needs_fire: assert property (@(posedge g_clk) disable iff (!arst_n)
            wb_valid |-> $past(fire))
            else begin
                $error("Writeback pulse without an accepted request");
                fail_count++;
            end

        wb_low_in_reset: assert property (@(posedge g_clk)
            !arst_n |-> !wb_valid)
            else begin
                $error("Writeback pulse during reset");
                fail_count++;
            end
    end

endmodule

// Handshake side, writeback inputs unused
bind riscv_crypto_fu crypto_unit_asserts #(.WB_SIDE(1'b0)) fu_asserts_i (
    .g_clk     (g_clk),
    .arst_n    (arst_n),
    .req_valid (req.valid),
    .ready     (ready),
    .fire      (1'b0),
    .wb_valid  (1'b0)
);

// Writeback side, handshake inputs unused
bind crypto_wb crypto_unit_asserts #(.WB_SIDE(1'b1)) wb_asserts_i (
    .g_clk     (g_clk),
    .arst_n    (arst_n),
    .req_valid (1'b0),
    .ready     (1'b0),
    .fire      (fire),
    .wb_valid  (wb.valid)
);

// ==== tb/crypto_unit_tb.sv ====
`timescale 1ns/1ps

module crypto_unit_tb;
    import crypto_pkg::*;

    localparam int CLK_HALF   = 5;    // 10 ns period
    localparam int RST_CYCLES = 16;
    localparam int WAIT_LIMIT = 20;   // Cycles before a wait gives up
    localparam int RAND_VECS  = 200;
    localparam int BURST_LEN  = 8;
    localparam int SEED       = 1321;

    logic        g_clk;
    logic        arst_n;
    crypto_req_t req;
    logic        ready;
    crypto_wb_t  wb;

    int errors;       // Value mismatches
    int checks;       // Compares done
    int timeouts;     // Waits that gave up
    int assert_fails; // Failed bound assertions

    // Fixed stimulus table
    logic [3:0]  vec_op[$];
    logic [63:0] vec_rs1[$];
    logic [4:0]  vec_rd[$];
    logic [63:0] vec_exp[$];

    // Back-to-back burst
    logic [3:0]  burst_op  [BURST_LEN];
    logic [63:0] burst_rs1 [BURST_LEN];
    logic [4:0]  burst_rd  [BURST_LEN];

    crypto_unit_top #(
        .SSHA256_EN   (1'b1),
        .SSHA512_EN   (1'b1),
        .SSM3_EN      (1'b1),
        .LOGIC_GATING (1'b1)
    ) dut_i (
        .g_clk  (g_clk),
        .arst_n (arst_n),
        .req    (req),
        .ready  (ready),
        .wb     (wb)
    );

    always #CLK_HALF g_clk = ~g_clk;

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic logic [31:0] rotr32(input logic [31:0] x, input int n);
        logic [63:0] dbl;
        dbl = {x, x} >> n; // Wrapped bits fall into the low half
        return dbl[31:0];
    endfunction

    function automatic logic [63:0] rotr64(input logic [63:0] x, input int n);
        logic [127:0] dbl;
        dbl = {x, x} >> n;
        return dbl[63:0];
    endfunction

    function automatic logic [63:0] sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    function automatic logic [63:0] expected_result(input logic [3:0] op, input logic [63:0] x);
        logic [31:0] w;
        w = x[31:0]; // 32-bit groups only look here
        case (op)
            op_sha256_sig0: return sext32(rotr32(w, 7) ^ rotr32(w, 18) ^ (w >> 3));
            op_sha256_sig1: return sext32(rotr32(w, 17) ^ rotr32(w, 19) ^ (w >> 10));
            op_sha256_sum0: return sext32(rotr32(w, 2) ^ rotr32(w, 13) ^ rotr32(w, 22));
            op_sha256_sum1: return sext32(rotr32(w, 6) ^ rotr32(w, 11) ^ rotr32(w, 25));
            op_sha512_sig0: return rotr64(x, 1) ^ rotr64(x, 8) ^ (x >> 7);
            op_sha512_sig1: return rotr64(x, 19) ^ rotr64(x, 61) ^ (x >> 6);
            op_sha512_sum0: return rotr64(x, 28) ^ rotr64(x, 34) ^ rotr64(x, 39);
            op_sha512_sum1: return rotr64(x, 14) ^ rotr64(x, 18) ^ rotr64(x, 41);
            op_sm3_p0:      return sext32(w ^ rotr32(w, 23) ^ rotr32(w, 15)); // rol 9, rol 17
            op_sm3_p1:      return sext32(w ^ rotr32(w, 17) ^ rotr32(w, 9));  // rol 15, rol 23
            default:        return 64'h0;
        endcase
    endfunction

    function automatic bit uses_low_word(input logic [3:0] op);
        return !(op inside {op_sha512_sig0, op_sha512_sig1, op_sha512_sum0, op_sha512_sum1});
    endfunction

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic add_vec(input crypto_op_e op, input logic [63:0] rs1, input logic [4:0] rd,
                           input logic [63:0] exp);
        vec_op.push_back(op);
        vec_rs1.push_back(rs1);
        vec_rd.push_back(rd);
        vec_exp.push_back(exp);
    endtask

    task automatic load_table;
        add_vec(op_sha256_sig0, 64'h1,                   5'd1,  64'h0000_0000_0200_4000);
        add_vec(op_sha256_sig1, 64'h1,                   5'd2,  64'h0000_0000_0000_a000);
        add_vec(op_sha256_sum0, 64'h1,                   5'd3,  64'h0000_0000_4008_0400);
        add_vec(op_sha256_sum1, 64'h1,                   5'd4,  64'h0000_0000_0420_0080);
        add_vec(op_sha256_sum0, 64'h2,                   5'd5,  64'hffff_ffff_8010_0800);
        add_vec(op_sha256_sig0, 64'h80,                  5'd6,  64'h0000_0000_0020_0011);
        add_vec(op_sha512_sig0, 64'h1,                   5'd7,  64'h8100_0000_0000_0000);
        add_vec(op_sha512_sig1, 64'h1,                   5'd8,  64'h0000_2000_0000_0008);
        add_vec(op_sha512_sum0, 64'h1,                   5'd9,  64'h0000_0010_4200_0000);
        add_vec(op_sha512_sum1, 64'h1,                   5'd10, 64'h0004_4000_0080_0000);
        add_vec(op_sha512_sig0, 64'h8000_0000_0000_0000, 5'd11, 64'h4180_0000_0000_0000);
        add_vec(op_sm3_p0,      64'h1,                   5'd12, 64'h0000_0000_0002_0201);
        add_vec(op_sm3_p1,      64'h1,                   5'd13, 64'h0000_0000_0080_8001);
        add_vec(op_sm3_p0,      64'h8000_0000,           5'd14, 64'hffff_ffff_8001_0100);
        add_vec(op_sm3_p1,      64'h100,                 5'd15, 64'hffff_ffff_8080_0100);
    endtask

    task automatic drive_req(input logic [3:0] op, input logic [63:0] rs1, input logic [4:0] rd);
        req.valid   = 1'b1;
        req.op      = crypto_op_e'(op);
        req.rs1     = rs1;
        req.rd_addr = rd;
        req.imm     = 4'h0;
    endtask

    // One request, entered and left on a falling edge
    task automatic run_single(input logic [3:0] op, input logic [63:0] rs1, input logic [4:0] rd,
                              input logic [63:0] exp);
        int cnt;
        cnt = 0;
        drive_req(op, rs1, rd);
        #1;
        check_value("ready", 1'b1, ready); // Same cycle as valid
        while (!ready && cnt < WAIT_LIMIT) begin
            @(negedge g_clk);
            #1;
            cnt++;
        end
        if (!ready) begin
            timeouts++;
            $display("Timed out waiting for ready on opcode %0d at %0t", op, $time);
            req.valid = 1'b0;
            return;
        end
        @(negedge g_clk); // Accepted on the rising edge just passed
        req.valid = 1'b0;
        cnt = 0;
        while (!wb.valid && cnt < WAIT_LIMIT) begin
            @(negedge g_clk);
            cnt++;
        end
        if (!wb.valid) begin
            timeouts++;
            $display("Timed out waiting for the writeback pulse at %0t", $time);
            return;
        end
        check_value("wb.valid delay", 0, cnt);
        check_value("wb.rd_addr", rd, wb.rd_addr);
        check_value("wb.data", exp, wb.data);
        @(negedge g_clk);
        check_value("wb.valid", 1'b0, wb.valid); // Single cycle pulse
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        logic [63:0] rs1_val;
        logic [3:0]  op_val;
        logic [4:0]  rd_val;
        void'($urandom(SEED));
        errors       = 0;
        checks       = 0;
        timeouts     = 0;
        assert_fails = 0;
        g_clk        = 1'b0;
        arst_n       = 1'b0;
        req          = '0;
        load_table();
        repeat (RST_CYCLES) @(posedge g_clk);
        @(negedge g_clk);
        arst_n = 1'b1;
        check_value("wb.valid", 1'b0, wb.valid); // Reset state
        check_value("wb.data", 64'h0, wb.data);

        // Fixed vectors, junk in the upper word for 32-bit groups
        for (int i = 0; i < vec_op.size(); i++) begin
            rs1_val = vec_rs1[i];
            if (uses_low_word(vec_op[i])) begin
                rs1_val[63:32] = $urandom;
            end
            run_single(vec_op[i], rs1_val, vec_rd[i], vec_exp[i]);
        end

        // Random vectors
        for (int i = 0; i < RAND_VECS; i++) begin
            op_val  = 4'($urandom % 10 + 1);
            rs1_val = {$urandom, $urandom};
            rd_val  = 5'($urandom);
            run_single(op_val, rs1_val, rd_val, expected_result(op_val, rs1_val));
        end

        // Valid low means no handshake
        req.op  = op_sha512_sum0;
        req.rs1 = 64'h0123_4567_89ab_cdef;
        #1;
        check_value("ready", 1'b0, ready);
        @(negedge g_clk);
        check_value("wb.valid", 1'b0, wb.valid);
        req.valid = 1'b1; // Unknown opcode is never accepted
        req.op    = op_none;
        #1;
        check_value("ready", 1'b0, ready);
        @(negedge g_clk);
        check_value("wb.valid", 1'b0, wb.valid);
        req.valid = 1'b0;
        @(negedge g_clk);

        // ------------------------------
        // Back-to-back burst
        // ------------------------------
        for (int k = 0; k <= BURST_LEN; k++) begin
            if (k < BURST_LEN) begin
                burst_op[k]  = 4'($urandom % 10 + 1);
                burst_rs1[k] = {$urandom, $urandom};
                burst_rd[k]  = 5'($urandom);
                drive_req(burst_op[k], burst_rs1[k], burst_rd[k]);
            end else begin
                req.valid = 1'b0;
            end
            if (k > 0) begin
                check_value("wb.valid", 1'b1, wb.valid); // Previous request lands now
                check_value("wb.rd_addr", burst_rd[k-1], wb.rd_addr);
                check_value("wb.data", expected_result(burst_op[k-1], burst_rs1[k-1]), wb.data);
            end
            #1;
            if (k < BURST_LEN) begin
                check_value("ready", 1'b1, ready);
            end
            @(negedge g_clk);
        end
        check_value("wb.valid", 1'b0, wb.valid);

        // Failures seen by the bound checkers
        assert_fails = dut_i.i_crypto_fu.fu_asserts_i.fail_count +
                       dut_i.i_crypto_wb.wb_asserts_i.fail_count;

        $display("Checks run: %0d, mismatches: %0d, timeouts: %0d, assertion failures: %0d",
                 checks, errors, timeouts, assert_fails);
        if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
common/crypto_pkg.sv
crypto_fu/riscv_crypto_fu_ssha256.sv
crypto_fu/riscv_crypto_fu_ssha512.sv
crypto_fu/riscv_crypto_fu_ssm3.sv
crypto_fu/riscv_crypto_fu.sv
logic/crypto_wb.sv
logic/crypto_unit_top.sv
tb/crypto_unit_asserts.sv
tb/crypto_unit_tb.sv
